//--- logic/tap_pkg.sv
// shared TAP definitions, imported by the RTL stages and the testbench model
`default_nettype none

package tap_pkg;

    // number of LEDs on the board
    // the state code is shown inverted since the LEDs are active low
    localparam int LED_WIDTH = 6;

    // the sixteen states of the IEEE 1149.1 TAP controller
    // codes follow the board's LED numbering
    typedef enum logic [3:0] {
        // reset and idle
        TEST_LOGIC_RESET = 4'd0,
        RUN_TEST_IDLE    = 4'd1,
        // data register column
        SELECT_DR_SCAN   = 4'd2,
        CAPTURE_DR       = 4'd3,
        SHIFT_DR         = 4'd4,
        EXIT1_DR         = 4'd5,
        PAUSE_DR         = 4'd6,
        EXIT2_DR         = 4'd7,
        UPDATE_DR        = 4'd8,
        // instruction register column
        SELECT_IR_SCAN   = 4'd9,
        CAPTURE_IR       = 4'd10,
        SHIFT_IR         = 4'd11,
        EXIT1_IR         = 4'd12,
        PAUSE_IR         = 4'd13,
        EXIT2_IR         = 4'd14,
        UPDATE_IR        = 4'd15
    } tap_state_e;

    // five high TMS bits reach TEST_LOGIC_RESET from any state
    // the testbench relies on this when it forces a reset

endpackage : tap_pkg

`default_nettype wire

//--- logic/tap_ctrl_if.sv
// decoded TAP state and instruction register strobes, passed from decode to execute and result
`default_nettype none
`timescale 1ns/1ps

interface tap_ctrl_if
    import tap_pkg::*;
();

    // current TAP state as held by the decode stage
    tap_state_e state;

    // high for the whole TEST_LOGIC_RESET state
    logic ir_reset;

    // high on a SHIFT_IR cycle where TMS is low
    // this is the cycle where the register really moves
    logic ir_shift;

    // high for the whole UPDATE_IR state
    logic ir_update;

    // high for the whole SHIFT_IR state, whatever TMS does
    logic in_shift_ir;

    // decode owns every signal
    modport decode (
        output state,
        output ir_reset,
        output ir_shift,
        output ir_update,
        output in_shift_ir
    );

    // execute only needs the instruction register strobes
    modport execute (
        input ir_reset,
        input ir_shift,
        input ir_update
    );

    // result needs the state for the LEDs and the TDO gate
    modport result (
        input state,
        input in_shift_ir
    );

endinterface : tap_ctrl_if

`default_nettype wire

//--- logic/tap_state_decode.sv
// TAP controller state register and next-state table, steered by jtag_tms on rising jtag_clk
`default_nettype none
`timescale 1ns/1ps

module tap_state_decode
    import tap_pkg::*;
(
    input  wire         jtag_clk,
    input  wire         sys_rst_n,
    input  wire         jtag_tms,
    tap_ctrl_if.decode  ctrl
);

    // current and next state
    tap_state_e state_q;
    tap_state_e state_d;

    // next-state table of the standard TAP controller
    // each state has exactly two successors selected by TMS
    always_comb
    begin
        case (state_q)
            // stays in reset while TMS is high
            TEST_LOGIC_RESET:
                state_d = jtag_tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:
                state_d = jtag_tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;

            // data register column
            SELECT_DR_SCAN:
                state_d = jtag_tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:
                state_d = jtag_tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:
                state_d = jtag_tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:
                state_d = jtag_tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:
                state_d = jtag_tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:
                state_d = jtag_tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:
                state_d = jtag_tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;

            // instruction register column
            // high TMS in SELECT_IR_SCAN wraps back to reset
            SELECT_IR_SCAN:
                state_d = jtag_tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            // capture loads nothing into the instruction register here
            CAPTURE_IR:
                state_d = jtag_tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:
                state_d = jtag_tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:
                state_d = jtag_tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:
                state_d = jtag_tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:
                state_d = jtag_tms ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:
                state_d = jtag_tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;

            // unreachable with a 4-bit enum of sixteen codes
            default:
                state_d = TEST_LOGIC_RESET;
        endcase
    end

    // state register
    // one rising edge from the sampled TMS to the new state
    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            state_q <= TEST_LOGIC_RESET;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // all state decoding for the other stages lives here
    assign ctrl.state       = state_q;

    // clear request for the instruction register
    assign ctrl.ir_reset    = (state_q == TEST_LOGIC_RESET);

    // shift happens on SHIFT_IR edges that stay in SHIFT_IR
    // a high TMS leaves for EXIT1_IR without shifting
    assign ctrl.ir_shift    = (state_q == SHIFT_IR) && !jtag_tms;

    // parallel latch of the shifted word
    assign ctrl.ir_update   = (state_q == UPDATE_IR);

    // TDO gate for the result stage
    assign ctrl.in_shift_ir = (state_q == SHIFT_IR);

endmodule : tap_state_decode

`default_nettype wire

//--- logic/ir_shift_execute.sv
// instruction shift register with shifted-out bit and UPDATE_IR latch, driven by the decode strobes
`default_nettype none
`timescale 1ns/1ps

module ir_shift_execute #(
    parameter int IR_WIDTH = 32
) (
    input  wire                 jtag_clk,
    input  wire                 sys_rst_n,
    input  wire                 jtag_tdi,
    tap_ctrl_if.execute         ctrl,
    output logic                shift_out,
    output logic [IR_WIDTH-1:0] ir_value
);

    // shift chain between TDI and TDO
    logic [IR_WIDTH-1:0] ir_shift_q;
    // chain value after one shift
    logic [IR_WIDTH-1:0] ir_shift_d;
    // bit 0 as it was before the last shift
    logic                shift_out_q;
    // parallel instruction value
    logic [IR_WIDTH-1:0] ir_value_q;

    // shift right and put TDI in at the top
    // written as shift then overwrite so a 1-bit register works too
    always_comb
    begin
        ir_shift_d = ir_shift_q >> 1;
        ir_shift_d[IR_WIDTH-1] = jtag_tdi;
    end

    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            ir_shift_q  <= '0;
            ir_value_q  <= '0;
            shift_out_q <= 1'b0;
        end
        // TEST_LOGIC_RESET wins over shift and update
        else if (ctrl.ir_reset)
        begin
            ir_shift_q <= '0;
            ir_value_q <= '0;
        end
        else
        begin
            // keep the outgoing bit for the falling-edge TDO register
            if (ctrl.ir_shift)
            begin
                shift_out_q <= ir_shift_q[0];
                ir_shift_q  <= ir_shift_d;
            end
            // shift and update never share a state
            if (ctrl.ir_update)
            begin
                ir_value_q <= ir_shift_q;
            end
        end
    end

    assign shift_out = shift_out_q;
    assign ir_value  = ir_value_q;

endmodule : ir_shift_execute

`default_nettype wire

//--- logic/tap_result.sv
// active-low LED state display and falling-edge jtag_tdo register
`default_nettype none
`timescale 1ns/1ps

module tap_result
    import tap_pkg::*;
(
    input  wire                  jtag_clk,
    input  wire                  sys_rst_n,
    input  wire                  shift_out,
    tap_ctrl_if.result           ctrl,
    output logic [LED_WIDTH-1:0] led,
    output logic                 jtag_tdo
);

    // state code widened to the LED count
    logic [LED_WIDTH-1:0] state_code;
    // TDO holding register on the falling edge
    logic                 tdo_q;
    // value TDO takes at the next falling edge
    logic                 tdo_d;

    // zero-extend the 4-bit code
    assign state_code = LED_WIDTH'(ctrl.state);

    // LEDs light on a low pin
    // so a set code bit must drive the pin low
    // reset state code 0 leaves all LEDs dark
    assign led = ~state_code;

    // only SHIFT_IR puts data on TDO
    // the other states hold the line low
    always_comb
    begin
        if (ctrl.in_shift_ir)
        begin
            tdo_d = shift_out;
        end
        else
        begin
            tdo_d = 1'b0;
        end
    end

    // TDI and TMS are sampled on the rising edge
    // TDO must change on the falling edge
    // so it is stable when the host samples it
    always_ff @(negedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            tdo_q <= 1'b0;
        end
        else
        begin
            tdo_q <= tdo_d;
        end
    end

    assign jtag_tdo = tdo_q;

endmodule : tap_result

`default_nettype wire

//--- logic/tap_monitor_top.sv
// JTAG TAP monitor top level with board pins, wiring decode, execute and result stages
`default_nettype none
`timescale 1ns/1ps

module tap_monitor_top
    import tap_pkg::*;
#(
    parameter int IR_WIDTH = 32
) (
    input  wire                  jtag_clk,
    input  wire                  sys_rst_n,
    input  wire                  jtag_tms,
    input  wire                  jtag_tdi,
    output logic                 jtag_tdo,
    output logic [LED_WIDTH-1:0] led,
    output logic [IR_WIDTH-1:0]  ir_value
);

    // state and strobes from decode to the other stages
    tap_ctrl_if ctrl_if ();

    // bit leaving the instruction register, headed for TDO
    logic shift_out;

    // decode
    // the TAP state machine
    tap_state_decode tap_state_decode_i (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .jtag_tms  (jtag_tms),
        .ctrl      (ctrl_if.decode)
    );

    // execute
    // instruction register, width set from here
    ir_shift_execute #(
        .IR_WIDTH (IR_WIDTH)
    ) ir_shift_execute_i (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .jtag_tdi  (jtag_tdi),
        .ctrl      (ctrl_if.execute),
        .shift_out (shift_out),
        .ir_value  (ir_value)
    );

    // result
    // LEDs and TDO
    tap_result tap_result_i (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .shift_out (shift_out),
        .ctrl      (ctrl_if.result),
        .led       (led),
        .jtag_tdo  (jtag_tdo)
    );

endmodule : tap_monitor_top

`default_nettype wire

//--- test/tap_tb.sv
// testbench for the TAP monitor that checks LEDs, TDO and the instruction value against a TAP model
`default_nettype none
`timescale 1ns/1ps

module tap_tb
    import tap_pkg::*;
();

    localparam int IR_WIDTH     = 32;
    localparam int CHK_WIDTH    = (IR_WIDTH > LED_WIDTH) ? IR_WIDTH : LED_WIDTH;
    localparam int RANDOM_STEPS = 200;

    // DUT pins
    logic                 jtag_clk;
    logic                 sys_rst_n;
    logic                 jtag_tms;
    logic                 jtag_tdi;
    logic                 jtag_tdo;
    logic [LED_WIDTH-1:0] led;
    logic [IR_WIDTH-1:0]  ir_value;

    // reference TAP model stepped on each rising edge
    tap_state_e           model_state;
    logic [IR_WIDTH-1:0]  model_ir;
    logic [IR_WIDTH-1:0]  model_value;
    logic                 model_shift_out;

    logic [15:0]          lfsr_state;
    // error and check counters
    int                   error_count;
    int                   check_count;
    int                   tdo_errors;
    int                   tdo_checks;
    int                   idle_errors;
    int                   test_errors;
    // falling-edge TDO sample
    logic                 last_tdo;
    logic                 expected_tdo;
    logic                 tdo_check_on = 1'b0;
    logic [IR_WIDTH-1:0]  first_word;
    logic [IR_WIDTH-1:0]  second_word;

    tap_monitor_top #(
        .IR_WIDTH (IR_WIDTH)
    ) tap_monitor_top_i (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .jtag_tms  (jtag_tms),
        .jtag_tdi  (jtag_tdi),
        .jtag_tdo  (jtag_tdo),
        .led       (led),
        .ir_value  (ir_value)
    );

    // 10 ns clock
    initial
    begin
        jtag_clk = 1'b0;
        forever
        begin
            #5 jtag_clk = ~jtag_clk;
        end
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one LFSR step per bit taken
    function logic random_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    // IEEE 1149.1 TAP transitions from the standard diagram
    function automatic tap_state_e expected_next(input tap_state_e s, input logic tms);
        case (s)
            TEST_LOGIC_RESET: return tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   return tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       return tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         return tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         return tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         return tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         return tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   return tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       return tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         return tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         return tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         return tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         return tms ? UPDATE_IR : SHIFT_IR;
            default:          return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
        endcase
    endfunction

    function automatic int total_errors();
        return error_count + tdo_errors + idle_errors;
    endfunction

    task automatic check_value(input string name, input logic [CHK_WIDTH-1:0] expected,
                               input logic [CHK_WIDTH-1:0] actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("FAILED %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, total_errors() - test_errors);
        test_errors = total_errors();
    endtask

    // drive one TMS/TDI pair, step the model on the rising edge, then compare
    task automatic clock_cycle(input logic tms, input logic tdi);
        logic [LED_WIDTH-1:0] expected_led;
        jtag_tms = tms;
        jtag_tdi = tdi;
        @(posedge jtag_clk);
        if (!sys_rst_n || model_state == TEST_LOGIC_RESET)
        begin
            model_ir    = '0;
            model_value = '0;
        end
        else
        begin
            if (model_state == SHIFT_IR && !tms)
            begin
                model_shift_out = model_ir[0];
                model_ir        = (model_ir >> 1) | (IR_WIDTH'(tdi) << (IR_WIDTH - 1));
            end
            if (model_state == UPDATE_IR)
            begin
                model_value = model_ir;
            end
        end
        if (!sys_rst_n)
        begin
            model_state     = TEST_LOGIC_RESET;
            model_shift_out = 1'b0;
        end
        else
        begin
            model_state = expected_next(model_state, tms);
        end
        #1;
        // active-low LEDs show the inverted state code
        expected_led = ~LED_WIDTH'(model_state);
        check_value("led", CHK_WIDTH'(expected_led), CHK_WIDTH'(led));
        check_value("ir_value", CHK_WIDTH'(model_value), CHK_WIDTH'(ir_value));
    endtask

    // hold TMS until the LEDs show the target state or the cycle limit runs out
    task automatic wait_for_state(input tap_state_e target, input logic tms, input int limit);
        int                   cycles;
        logic [LED_WIDTH-1:0] target_led;
        cycles     = 0;
        target_led = ~LED_WIDTH'(target);
        while (led !== target_led && cycles < limit)
        begin
            clock_cycle(tms, random_bit());
            cycles++;
        end
        if (led !== target_led)
        begin
            error_count++;
            $display("timeout: the TAP did not reach %s within %0d cycles", target.name(), limit);
        end
    endtask

    // TDO follows shift_out in SHIFT_IR only
    // sampled just after the falling edge
    always @(negedge jtag_clk)
    begin
        if (tdo_check_on)
        begin
            expected_tdo = (sys_rst_n && model_state == SHIFT_IR) ? model_shift_out : 1'b0;
            #1;
            last_tdo = jtag_tdo;
            tdo_checks++;
            assert (jtag_tdo === expected_tdo)
            else
            begin
                tdo_errors++;
                $display("FAILED %0t jtag_tdo expected %b got %b", $time, expected_tdo, jtag_tdo);
            end
        end
    end

    // outside SHIFT_IR the line stays low
    tdo_idle_low: assert property (@(posedge jtag_clk) disable iff (!sys_rst_n)
        (model_state != SHIFT_IR) |-> !jtag_tdo)
    else
    begin
        idle_errors++;
        $display("FAILED %0t jtag_tdo expected 0 got %b", $time, jtag_tdo);
    end

    initial
    begin
        int                   i;
        int                   m;
        logic                 b;
        logic [LED_WIDTH-1:0] reset_led;
        sys_rst_n       = 1'b0;
        jtag_tms        = 1'b1;
        jtag_tdi        = 1'b0;
        lfsr_state      = 16'd14;
        error_count     = 0;
        check_count     = 0;
        tdo_errors      = 0;
        tdo_checks      = 0;
        idle_errors     = 0;
        test_errors     = 0;
        model_state     = TEST_LOGIC_RESET;
        model_ir        = '0;
        model_value     = '0;
        model_shift_out = 1'b0;
        first_word      = '0;
        second_word     = '0;
        reset_led       = '1;

        // reset held for 10 cycles
        clock_cycle(1'b1, 1'b0);
        tdo_check_on = 1'b1;
        repeat (9) clock_cycle(1'b1, 1'b0);
        sys_rst_n = 1'b1;
        check_value("led", CHK_WIDTH'(reset_led), CHK_WIDTH'(led));
        check_value("ir_value", '0, CHK_WIDTH'(ir_value));
        check_value("jtag_tdo", '0, CHK_WIDTH'(last_tdo));
        report_test("reset");

        // random walk through the state table
        for (i = 0; i < RANDOM_STEPS; i++)
        begin
            clock_cycle(random_bit(), random_bit());
        end
        report_test("state walk");

        // five high TMS bits from wherever the walk left off
        for (i = 0; i < 8; i++)
        begin
            repeat (4) clock_cycle(random_bit(), random_bit());
            repeat (5) clock_cycle(1'b1, random_bit());
            check_value("led", CHK_WIDTH'(reset_led), CHK_WIDTH'(led));
        end
        report_test("forced reset");

        // TLR -> RTI -> SDS -> SIS -> CIR -> SIR
        wait_for_state(RUN_TEST_IDLE, 1'b0, 2);
        clock_cycle(1'b1, 1'b0);
        clock_cycle(1'b1, 1'b0);
        wait_for_state(SHIFT_IR, 1'b0, 3);
        for (m = 0; m < IR_WIDTH; m++)
        begin
            b             = random_bit();
            first_word[m] = b;
            clock_cycle(1'b0, b);
        end
        // EXIT1_IR then UPDATE_IR
        // latch on the edge after
        clock_cycle(1'b1, 1'b0);
        wait_for_state(UPDATE_IR, 1'b1, 2);
        clock_cycle(1'b0, 1'b0);
        check_value("ir_value", CHK_WIDTH'(first_word), CHK_WIDTH'(ir_value));
        report_test("instruction load");

        // second scan pushes the first word out on TDO
        clock_cycle(1'b1, 1'b0);
        clock_cycle(1'b1, 1'b0);
        wait_for_state(SHIFT_IR, 1'b0, 3);
        for (m = 0; m < IR_WIDTH; m++)
        begin
            b              = random_bit();
            second_word[m] = b;
            clock_cycle(1'b0, b);
            // last_tdo holds the bit pushed out one edge earlier
            if (m > 0)
            begin
                check_value("jtag_tdo", CHK_WIDTH'(first_word[m-1]), CHK_WIDTH'(last_tdo));
            end
        end
        clock_cycle(1'b1, 1'b0);
        check_value("jtag_tdo", CHK_WIDTH'(first_word[IR_WIDTH-1]), CHK_WIDTH'(last_tdo));
        wait_for_state(UPDATE_IR, 1'b1, 2);
        // falling edge in EXIT1_IR
        check_value("jtag_tdo", '0, CHK_WIDTH'(last_tdo));
        clock_cycle(1'b0, 1'b0);
        check_value("ir_value", CHK_WIDTH'(second_word), CHK_WIDTH'(ir_value));
        report_test("shift-out order");

        // RTI -> SDS -> SIS -> TLR
        // cleared one edge later
        wait_for_state(TEST_LOGIC_RESET, 1'b1, 5);
        check_value("ir_value", CHK_WIDTH'(second_word), CHK_WIDTH'(ir_value));
        clock_cycle(1'b1, 1'b0);
        check_value("ir_value", '0, CHK_WIDTH'(ir_value));
        report_test("clear on reset state");

        $display("tests 6, checks %0d, errors %0d", check_count + tdo_checks, total_errors());
        if (total_errors() == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tap_tb

`default_nettype wire

//--- flist.f
logic/tap_pkg.sv
logic/tap_ctrl_if.sv
logic/tap_state_decode.sv
logic/ir_shift_execute.sv
logic/tap_result.sv
logic/tap_monitor_top.sv
test/tap_tb.sv

//--- Makefile
# Verilator build for the JTAG TAP monitor

VERILATOR  ?= verilator
TOP        ?= tap_tb
RTL_TOP    ?= tap_monitor_top
FILELIST   ?= flist.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   := All checks passed

SIM_EXE    := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# check the design alone, then the testbench on top of it
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --assert --top-module $(TOP) -f $(FILELIST)

$(SIM_EXE): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# pass only if the pass line shows up in the output
sim: $(SIM_EXE)
	@out="$$(./$(SIM_EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
